//--- Makefile
VERILATOR  = verilator
FLAGS      = --timing
TOP        = tb_aes_enc
FILELIST   = sim.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/aes_enc_core.sv
// aes_enc_core: AES-128 encryption engine with a row-serial ShiftRows stage
`timescale 1ns/10ps

module aes_enc_core (
  input  logic               clk,
  input  logic               resetn,
  input  logic               start,
  input  aes_pkg::aes_req_t  req,
  output logic               busy,
  output logic               done,
  output aes_pkg::aes_resp_t resp
);
  import aes_pkg::*;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_RUN,
    SEQ_FIN
  } seq_t;

  seq_t                            seq;
  logic [$clog2(ROUND_CYCLES)-1:0] cyc;
  logic [$clog2(NUM_ROUNDS):0]     round;
  logic [$clog2(ROW_COUNT)-1:0]    wb_row;
  logic [$clog2(ROUND_CYCLES)-1:0] sh_sel;
  logic                            accept;
  logic                            is_sub;
  logic                            is_mix;
  logic                            sh_wr;
  logic                            sh_full;
  logic                            sh_valid;
  aes_row_t                        sh_in;
  aes_row_t                        sh_out;
  aes_state_t                      st_q;
  aes_state_t                      sub_st;
  aes_state_t                      mix_st;
  aes_state_t                      mix_sel;
  aes_state_t                      round_key;

  // round phases by cycle: 0 sub, 1..5 shift, 6 mix
  assign accept  = start && !busy;
  assign is_sub  = (seq == SEQ_RUN) && (cyc == '0);
  assign is_mix  = (seq == SEQ_RUN) && (cyc == $bits(cyc)'(ROUND_CYCLES - 1));
  assign sh_wr   = is_sub;
  // rows go in on cycles 1..4, the fifth shift cycle drains the last one
  assign sh_full = (seq == SEQ_RUN) && (cyc >= $bits(cyc)'(1))
                   && (cyc <= $bits(cyc)'(ROW_COUNT));
  assign sh_sel  = cyc - 1'b1;

  // SubBytes, one S-box per state byte
  for (genvar c = 0; c < 4; c++)
  begin : g_col
    for (genvar r = 0; r < 4; r++)
    begin : g_row
      aes_sbox u_sbox (
        .in_byte  (st_q[c][r]),
        .out_byte (sub_st[c][r])
      );
    end

    mix_column u_mix (
      .col_in  (st_q[c]),
      .col_out (mix_st[c])
    );
  end

  // pick the row for this shift cycle out of the column-major state
  always_comb
  begin
    for (int c = 0; c < 4; c++)
      sh_in[c] = st_q[c][sh_sel[$bits(wb_row)-1:0]];
  end

  enc_row_shifter u_shifter (
    .clk       (clk),
    .resetn    (resetn),
    .wr_en     (sh_wr),
    .row_full  (sh_full),
    .inp       (sh_in),
    .outp      (sh_out),
    .out_valid (sh_valid)
  );

  key_expander u_keys (
    .clk       (clk),
    .resetn    (resetn),
    .load      (accept),
    .step      (is_mix),
    .key       (req.key),
    .round_key (round_key)
  );

  // last round has no MixColumns
  assign mix_sel = (round == $bits(round)'(NUM_ROUNDS)) ? st_q : mix_st;

  // sequencer
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      seq    <= SEQ_IDLE;
      cyc    <= '0;
      round  <= '0;
      wb_row <= '0;
      busy   <= 1'b0;
      done   <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      // shifted rows come back in order, 0 to 3
      if (sh_valid)
        wb_row <= wb_row + 1'b1;
      case (seq)
        SEQ_IDLE:
        begin
          if (accept)
          begin
            seq   <= SEQ_RUN;
            busy  <= 1'b1;
            cyc   <= '0;
            round <= $bits(round)'(1);
          end
        end
        SEQ_RUN:
        begin
          if (is_mix)
          begin
            cyc <= '0;
            if (round == $bits(round)'(NUM_ROUNDS))
              seq <= SEQ_FIN;
            else
              round <= round + 1'b1;
          end
          else
            cyc <= cyc + 1'b1;
        end
        SEQ_FIN:
        begin
          // ciphertext already sits in st_q
          seq  <= SEQ_IDLE;
          busy <= 1'b0;
          done <= 1'b1;
        end
        default:
          seq <= SEQ_IDLE;
      endcase
    end
  end

  // state register
  always_ff @(posedge clk)
  begin
    if (accept)
      st_q <= req.block ^ req.key;
    else if (is_sub)
      st_q <= sub_st;
    else if (sh_valid)
    begin
      for (int c = 0; c < 4; c++)
        st_q[c][wb_row] <= sh_out[c];
    end
    else if (is_mix)
      st_q <= mix_sel ^ round_key;
  end

  // held until the next accepted start
  assign resp.block = st_q;

endmodule

//--- hw/aes_pkg.sv
// aes_pkg: AES-128 state types, request and response structs, round constants and timing
package aes_pkg;

  // one state byte
  typedef logic [7:0] aes_byte_t;

  // one column or key word, byte 0 is the top row (msb byte)
  typedef aes_byte_t [0:3] aes_word_t;

  // one state row, byte 0 is column 0
  typedef aes_byte_t [0:3] aes_row_t;

  // full state, column-major as in FIPS-197
  // column 0 holds the first four input bytes
  typedef aes_word_t [0:3] aes_state_t;

  // encryption request, plaintext block plus cipher key
  typedef struct packed {
    aes_state_t block;
    aes_state_t key;
  } aes_req_t;

  // encryption response, ciphertext block
  typedef struct packed {
    aes_state_t block;
  } aes_resp_t;

  // rounds for a 128-bit key
  localparam int NUM_ROUNDS = 10;

  // rows per state, also the wrap point of the shifter row counter
  localparam int ROW_COUNT = 4;

  // round constants, index 0 is used for round key 1
  localparam aes_byte_t [0:NUM_ROUNDS-1] RCON = {
    8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
    8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
  };

  // cycles per round: sub, five shift cycles, mix
  localparam int ROUND_CYCLES = 7;

  // accept edge to done edge
  // ten rounds plus one cycle to raise done
  localparam int ENC_LATENCY = NUM_ROUNDS * ROUND_CYCLES + 1;

endpackage

//--- hw/aes_sbox.sv
// aes_sbox: forward AES S-box lookup for one byte
`timescale 1ns/10ps

module aes_sbox (
  input  aes_pkg::aes_byte_t in_byte,
  output aes_pkg::aes_byte_t out_byte
);
  import aes_pkg::*;

  // constant table, entry 0 first
  aes_byte_t [0:255] sbox_tbl;

  assign sbox_tbl = {
    // 0x00 - 0x1f
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    // 0x20 - 0x3f
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    // 0x40 - 0x5f
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    // 0x60 - 0x7f
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    // 0x80 - 0x9f
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    // 0xa0 - 0xbf
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    // 0xc0 - 0xdf
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    // 0xe0 - 0xff
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // plain ROM read, no clock
  assign out_byte = sbox_tbl[in_byte];

endmodule

//--- hw/enc_row_shifter.sv
// enc_row_shifter: registers one state row and rotates it left by its own row count
`timescale 1ns/10ps

module enc_row_shifter (
  input  logic              clk,
  input  logic              resetn,
  input  logic              wr_en,
  input  logic              row_full,
  input  aes_pkg::aes_row_t inp,
  output aes_pkg::aes_row_t outp,
  output logic              out_valid
);
  import aes_pkg::*;

  logic                         wr_en_q;
  logic                         row_full_q;
  aes_row_t                     row_q;
  logic [$clog2(ROW_COUNT)-1:0] row_idx;

  // strobes and row counter
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      wr_en_q    <= 1'b0;
      row_full_q <= 1'b0;
      row_idx    <= '0;
    end
    else
    begin
      wr_en_q    <= wr_en;
      row_full_q <= row_full;
      // one step per row handed out, wraps after the last row
      if (out_valid)
      begin
        if (row_idx == $bits(row_idx)'(ROW_COUNT - 1))
          row_idx <= '0;
        else
          row_idx <= row_idx + 1'b1;
      end
    end
  end

  // row payload
  always_ff @(posedge clk)
  begin
    row_q <= inp;
  end

  // only a full row that is not being overwritten counts
  assign out_valid = row_full_q && !wr_en_q;

  // rotate left: out column c takes in column c + row
  always_comb
  begin
    for (int c = 0; c < ROW_COUNT; c++)
      outp[c] = row_q[(c + int'(row_idx)) % ROW_COUNT];
  end

endmodule

//--- hw/key_expander.sv
// key_expander: AES-128 on-the-fly key schedule, one round key per step
`timescale 1ns/10ps

module key_expander (
  input  logic                clk,
  input  logic                resetn,
  input  logic                load,
  input  logic                step,
  input  aes_pkg::aes_state_t key,
  output aes_pkg::aes_state_t round_key
);
  import aes_pkg::*;

  // key of the previous round, the cipher key right after load
  aes_state_t                    key_q;
  logic [$clog2(NUM_ROUNDS)-1:0] rnd;
  aes_word_t                     rot_w;
  aes_word_t                     sub_w;
  aes_byte_t                     rcon;

  // RotWord on the last word
  assign rot_w = {key_q[3][1], key_q[3][2], key_q[3][3], key_q[3][0]};

  // SubWord, one S-box per byte
  for (genvar i = 0; i < 4; i++)
  begin : g_sub
    aes_sbox u_sbox (
      .in_byte  (rot_w[i]),
      .out_byte (sub_w[i])
    );
  end

  assign rcon = RCON[rnd];

  // key for the round in progress
  // word 0 from the schedule core, then the xor chain
  always_comb
  begin
    round_key[0] = key_q[0] ^ sub_w ^ {rcon, 24'h000000};
    round_key[1] = key_q[1] ^ round_key[0];
    round_key[2] = key_q[2] ^ round_key[1];
    round_key[3] = key_q[3] ^ round_key[2];
  end

  // round count, stays on the last rcon after round 10
  always_ff @(posedge clk)
  begin
    if (!resetn)
      rnd <= '0;
    else if (load)
      rnd <= '0;
    else if (step && rnd != $bits(rnd)'(NUM_ROUNDS - 1))
      rnd <= rnd + 1'b1;
  end

  // key payload
  always_ff @(posedge clk)
  begin
    if (load)
      key_q <= key;
    else if (step)
      key_q <= round_key;
  end

endmodule

//--- hw/mix_column.sv
// mix_column: AES MixColumns on one 32-bit column over GF(2^8)
`timescale 1ns/10ps

module mix_column (
  input  aes_pkg::aes_word_t col_in,
  output aes_pkg::aes_word_t col_out
);
  import aes_pkg::*;

  aes_byte_t a0;
  aes_byte_t a1;
  aes_byte_t a2;
  aes_byte_t a3;

  // multiply by 2, reduce by x^8 + x^4 + x^3 + x + 1
  function automatic aes_byte_t xtime(input aes_byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // a0 is the top row
  assign a0 = col_in[0];
  assign a1 = col_in[1];
  assign a2 = col_in[2];
  assign a3 = col_in[3];

  // matrix rows 2 3 1 1, rotated per output byte
  // 3*x written as 2*x ^ x
  assign col_out[0] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
  assign col_out[1] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
  assign col_out[2] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
  assign col_out[3] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);

endmodule

//--- sim.f
hw/aes_pkg.sv
hw/aes_sbox.sv
hw/enc_row_shifter.sv
hw/mix_column.sv
hw/key_expander.sv
hw/aes_enc_core.sv
test/tb_clock.sv
test/tb_aes_enc.sv

//--- test/tb_aes_enc.sv
// tb_aes_enc: testbench for the AES-128 encryption core with vectors, abort and random blocks
`timescale 1ns/10ps

module tb_aes_enc;
  import aes_pkg::*;

  // one table row
  typedef struct packed {
    aes_state_t block;
    aes_state_t key;
    aes_state_t ct;
  } vec_t;

  localparam int NUM_VEC = 3;
  // accept edge to done edge
  localparam int EXP_LATENCY = 71;
  // encryptions started over the whole run, aborted one included
  localparam int NUM_ENC = 21;
  // 80 cycles per encryption, plus reset, the watch after the abort and some slack
  localparam int CYCLE_LIMIT = NUM_ENC * 80 + 4 + EXP_LATENCY + 10;

  logic        clk;
  logic        por_n;
  logic        soft_rst_n;
  logic        resetn;
  logic        start;
  aes_req_t    req;
  logic        busy;
  logic        done;
  aes_resp_t   resp;
  vec_t        vec_tbl [0:NUM_VEC-1];
  logic [31:0] seed;
  int          cycles = 0;
  int          checks;
  int          errors;
  int          tests;

  // power-on reset and mid-run reset together
  assign resetn = por_n && soft_rst_n;

  tb_clock u_clock (
    .clk    (clk),
    .resetn (por_n)
  );

  aes_enc_core UUT (
    .clk    (clk),
    .resetn (resetn),
    .start  (start),
    .req    (req),
    .busy   (busy),
    .done   (done),
    .resp   (resp)
  );

  // numerical recipes LCG
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // four LCG words, column 0 first
  function automatic aes_state_t rand_block();
    aes_state_t b;
    for (int w = 0; w < 4; w++)
    begin
      seed = lcg_next(seed);
      b[w] = seed;
    end
    return b;
  endfunction

  function automatic aes_req_t make_req(input aes_state_t blk, input aes_state_t k);
    aes_req_t r;
    r.block = blk;
    r.key   = k;
    return r;
  endfunction

  task automatic check_resp(input string name, input aes_resp_t got, input aes_resp_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  // one line per finished test
  task automatic report_test(input string what, input int err_before);
    tests++;
    if (errors == err_before)
      $display("test %0d %s: ok", tests, what);
    else
      $display("test %0d %s: %0d errors", tests, what, errors - err_before);
  endtask

  // entered and left on a falling edge
  // alt is pulsed on start inject_at cycles in, while busy
  task automatic run_enc(input aes_req_t r, input aes_req_t alt, input int inject_at,
                         output aes_resp_t got);
    int k;
    start = 1'b1;
    req   = r;
    k     = 0;
    got   = '0;
    do
    begin
      @(negedge clk);
      k++;
      start = (k == inject_at);
      if (k == inject_at)
        req = alt;
      // busy must hold until done
      if (!done)
        check_bit("busy", busy, 1'b1);
    end while (!done && k < EXP_LATENCY + 8);
    if (!done)
    begin
      errors++;
      $display("done did not arrive within %0d cycles of the start", k);
    end
    else
    begin
      checks++;
      // accept edge sits before falling edge 1, done edge before falling edge k
      if (k - 1 != EXP_LATENCY)
      begin
        errors++;
        $display("done came %0d cycles after the start instead of %0d", k - 1, EXP_LATENCY);
      end
      check_bit("busy", busy, 1'b0);
      got = resp;
      // single-cycle pulse
      @(negedge clk);
      check_bit("done", done, 1'b0);
    end
  endtask

  // hard stop on a hang
  always @(posedge clk)
  begin
    cycles++;
    if (cycles > CYCLE_LIMIT)
    begin
      $display("timeout after %0d cycles, run stopped", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  initial
  begin
    aes_resp_t  got;
    aes_resp_t  again;
    aes_resp_t  exp;
    aes_state_t blk;
    int         e0;
    start      = 1'b0;
    req        = '0;
    soft_rst_n = 1'b1;
    seed       = 32'h8449;
    checks     = 0;
    errors     = 0;
    tests      = 0;
    // FIPS-197 appendix B and C.1, then all zero
    vec_tbl[0] = '{block: 128'h3243f6a8885a308d313198a2e0370734,
                   key:   128'h2b7e151628aed2a6abf7158809cf4f3c,
                   ct:    128'h3925841d02dc09fbdc118597196a0b32};
    vec_tbl[1] = '{block: 128'h00112233445566778899aabbccddeeff,
                   key:   128'h000102030405060708090a0b0c0d0e0f,
                   ct:    128'h69c4e0d86a7b0430d8cdb78070b4c55a};
    vec_tbl[2] = '{block: 128'h0,
                   key:   128'h0,
                   ct:    128'h66e94bd4ef8a2c3b884cfa59ca342b2e};
    wait (por_n);
    @(negedge clk);

    // table vectors with latency and pulse checks
    for (int i = 0; i < NUM_VEC; i++)
    begin
      e0 = errors;
      run_enc(make_req(vec_tbl[i].block, vec_tbl[i].key), '0, 0, got);
      exp.block = vec_tbl[i].ct;
      check_resp("resp", got, exp);
      report_test($sformatf("table vector %0d", i), e0);
    end

    // second start while busy must be dropped
    e0 = errors;
    run_enc(make_req(vec_tbl[0].block, vec_tbl[0].key),
            make_req(vec_tbl[1].block, vec_tbl[1].key), 10, got);
    exp.block = vec_tbl[0].ct;
    check_resp("resp", got, exp);
    report_test("start while busy", e0);

    // each start lands on the cycle after done
    e0 = errors;
    for (int i = 0; i < NUM_VEC; i++)
    begin
      run_enc(make_req(vec_tbl[i].block, vec_tbl[i].key), '0, 0, got);
      exp.block = vec_tbl[i].ct;
      check_resp("resp", got, exp);
    end
    report_test("back to back", e0);

    // abort mid-run by reset
    e0 = errors;
    start = 1'b1;
    req   = make_req(vec_tbl[0].block, vec_tbl[0].key);
    @(negedge clk);
    start = 1'b0;
    repeat (20) @(negedge clk);
    soft_rst_n = 1'b0;
    repeat (2) @(negedge clk);
    check_bit("busy", busy, 1'b0);
    soft_rst_n = 1'b1;
    // aborted run must stay dead past its own done time
    repeat (EXP_LATENCY)
    begin
      @(negedge clk);
      check_bit("busy", busy, 1'b0);
      check_bit("done", done, 1'b0);
    end
    run_enc(make_req(vec_tbl[1].block, vec_tbl[1].key), '0, 0, got);
    exp.block = vec_tbl[1].ct;
    check_resp("resp", got, exp);
    report_test("reset during run", e0);

    // random blocks, fixed key, run twice each
    for (int n = 0; n < 6; n++)
    begin
      e0  = errors;
      blk = rand_block();
      run_enc(make_req(blk, vec_tbl[0].key), '0, 0, got);
      run_enc(make_req(blk, vec_tbl[0].key), '0, 0, again);
      check_resp("resp", again, got);
      checks++;
      if (got.block == blk)
      begin
        errors++;
        $display("ciphertext equals the plaintext for block %h", blk);
      end
      report_test($sformatf("random block %0d", n), e0);
    end

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- test/tb_clock.sv
// tb_clock: testbench clock and power-on reset generator
`timescale 1ns/10ps

module tb_clock (
  output logic clk,
  output logic resetn
);

  // 100 ns period
  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // low for 4 rising edges, released on a falling edge
  initial
  begin
    resetn = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
  end

endmodule
